/* Bender.yml */
package:
  name: ppu

sources:
  - rtl/ppu_pkg.sv
  - rtl/posit_decode.sv
  - rtl/posit_mul.sv
  - rtl/compute_rounding.sv
  - rtl/pack_fields.sv
  - rtl/posit_encode.sv
  - rtl/ppu_stage.sv
  - rtl/ppu_top.sv
  - target: test
    files:
      - verification/tb_ppu.sv

/* rtl/compute_rounding.sv */
`timescale 1ns/1ps

module compute_rounding (
  input  logic signed [ppu_pkg::MANT_LEN_SIZE-1:0] frac_len,
  input  logic [ppu_pkg::FRAC_FULL_SIZE-1:0]       frac_full,
  input  logic [ppu_pkg::S+1:0]                    frac_len_diff,
  input  logic signed [ppu_pkg::K_SIZE-1:0]        k,
  input  logic [ppu_pkg::ES-1:0]                   exp,
  input  logic                                     frac_truncated,
  output logic                                     round_bit,
  output logic                                     sticky_bit
);
  import ppu_pkg::*;

  logic [FRAC_FULL_SIZE-1:0] frac_shifted;
  logic [FRAC_FULL_SIZE-1:0] below_mask;
  logic [ES-1:0]             exp_shifted;
  logic [ES-1:0]             exp_below;
  int                        exp_pos;

  assign frac_shifted = frac_full >> (frac_len_diff - 1);
  assign below_mask   = {FRAC_FULL_SIZE{1'b1}} >> (FRAC_FULL_SIZE + 1 - frac_len_diff);

  assign exp_pos     = -int'(frac_len) - 1;  // first exponent bit that does not fit
  assign exp_shifted = exp >> exp_pos;
  assign exp_below   = exp & ~({ES{1'b1}} << exp_pos);

  always_comb begin
    if (frac_len >= 0) begin
      round_bit  = frac_shifted[0];
      sticky_bit = (|(frac_full & below_mask)) | frac_truncated;
    end else if (frac_len >= -ES) begin
      round_bit  = exp_shifted[0];
      sticky_bit = (|exp_below) | (|frac_full) | frac_truncated;
    end else begin
      round_bit  = k[K_SIZE-1];  // regime terminator is lost, 1 only for a zero run
      sticky_bit = (|exp) | (|frac_full) | frac_truncated;
    end
  end

endmodule : compute_rounding

/* rtl/pack_fields.sv */
`timescale 1ns/1ps

module pack_fields (
  input  logic [ppu_pkg::FRAC_FULL_SIZE-1:0] frac_full,
  input  logic signed [ppu_pkg::TE_SIZE-1:0] total_exp,
  input  logic                               frac_truncated,
  output logic signed [ppu_pkg::K_SIZE-1:0]  k,
  output logic [ppu_pkg::ES-1:0]             next_exp,
  output logic [ppu_pkg::MANT_SIZE-1:0]      frac,
  output logic                               round_bit,
  output logic                               sticky_bit,
  output logic                               k_is_oob,
  output logic                               non_zero_frac_field_size
);
  import ppu_pkg::*;

  logic signed [K_SIZE-1:0]        k_unpacked;
  logic [ES-1:0]                   exp_unpacked;
  logic [REG_LEN_SIZE-1:0]         reg_len;
  logic signed [MANT_LEN_SIZE-1:0] frac_len;
  logic signed [ES:0]              es_actual_len;  // below zero when the regime overruns
  logic [ES:0]                     exp_drop;
  logic [S+1:0]                    frac_len_diff;

  assign k_unpacked   = K_SIZE'(total_exp >>> ES);
  assign exp_unpacked = total_exp[ES-1:0];

  // regime range of an N-bit word is +-(N-2)
  assign k        = K_SIZE'(max(2 - N, min(N - 2, int'(k_unpacked))));
  assign k_is_oob = k != k_unpacked;

  assign reg_len  = (k >= 0) ? REG_LEN_SIZE'(k + 2) : REG_LEN_SIZE'(1 - k);
  assign frac_len = MANT_LEN_SIZE'(N - 1 - ES - int'(reg_len));

  assign es_actual_len = (ES + 1)'(min(ES, N - 1 - int'(reg_len)));
  assign exp_drop      = (ES + 1)'(ES - es_actual_len);

  // exponent bits that fall off the word end are cleared, the rest stay left aligned
  assign next_exp = (exp_unpacked >> exp_drop) << exp_drop;

  assign frac_len_diff = (S + 2)'(FRAC_FULL_SIZE - frac_len);
  assign frac          = MANT_SIZE'(frac_full >> frac_len_diff);

  assign non_zero_frac_field_size = frac_len > 0;

  compute_rounding compute_rounding_inst (
    .frac_len      (frac_len),
    .frac_full     (frac_full),
    .frac_len_diff (frac_len_diff),
    .k             (k),
    .exp           (exp_unpacked),
    .frac_truncated(frac_truncated),
    .round_bit     (round_bit),
    .sticky_bit    (sticky_bit)
  );

  always_comb begin
    if (!$isunknown(frac_len)) begin
      assert #0 (frac_len <= MANT_SIZE)
        else $error("pack_fields: fraction length %0d exceeds field", frac_len);
    end
  end

endmodule : pack_fields

/* rtl/posit_decode.sv */
`timescale 1ns/1ps

module posit_decode (
  input  ppu_pkg::posit_t                   word,
  output logic                              sign,
  output logic signed [ppu_pkg::K_SIZE-1:0] k,
  output logic [ppu_pkg::ES-1:0]            exp,
  output logic [ppu_pkg::MANT_SIZE:0]       mant,
  output logic                              is_zero,
  output logic                              is_nar
);
  import ppu_pkg::*;

  posit_t       mag;
  logic [N-2:0] body;
  logic [N-2:0] rest;
  int           run;
  logic         run_done;

  assign sign    = word[N-1];
  assign is_zero = word == '0;
  assign is_nar  = word == POSIT_NAR;

  assign mag  = sign ? posit_t'(-word) : word;  // magnitude of a negative posit
  assign body = mag[N-2:0];

  // length of the regime run, counted from the bit below the sign
  always_comb begin
    run      = 0;
    run_done = 1'b0;
    for (int i = N - 2; i >= 0; i--) begin
      if (!run_done && body[i] == body[N-2]) begin
        run = run + 1;
      end else begin
        run_done = 1'b1;
      end
    end
  end

  assign k = body[N-2] ? K_SIZE'(run - 1) : K_SIZE'(-run);

  // drop run and terminator, zeros fill in where the word runs out
  assign rest = body << (run + 1);

  assign exp  = rest[N-2 -: ES];
  assign mant = {1'b1, rest[N-2-ES -: MANT_SIZE]};  // hidden bit set

endmodule : posit_decode

/* rtl/posit_encode.sv */
`timescale 1ns/1ps

module posit_encode (
  input  logic                              sign,
  input  logic                              is_zero,
  input  logic                              is_nar,
  input  logic signed [ppu_pkg::K_SIZE-1:0] k,
  input  logic [ppu_pkg::ES-1:0]            next_exp,
  input  logic [ppu_pkg::MANT_SIZE-1:0]     frac,
  input  logic                              round_bit,
  input  logic                              sticky_bit,
  input  logic                              k_is_oob,
  output ppu_pkg::posit_t                   word
);
  import ppu_pkg::*;

  logic [REG_LEN_SIZE-1:0]         reg_len;
  logic signed [MANT_LEN_SIZE-1:0] frac_len;
  logic [2*N-1:0]                  regime_bits;
  logic [2*N-1:0]                  chain;
  logic [N-2:0]                    body;
  logic                            round_up;
  posit_t                          mag;
  posit_t                          signed_word;

  assign reg_len  = (k >= 0) ? REG_LEN_SIZE'(k + 2) : REG_LEN_SIZE'(1 - k);
  assign frac_len = MANT_LEN_SIZE'(N - 1 - ES - int'(reg_len));

  // k+1 ones and a closing 0, or -k zeros and a closing 1
  assign regime_bits = (k >= 0) ? ((2 * N)'(1) << (k + 2)) - (2 * N)'(2) : (2 * N)'(1);
  assign chain       = (regime_bits << ES) | (2 * N)'(next_exp);

  // short regime leaves room for frac, long regime pushes low bits off the word
  assign body = (frac_len >= 0) ? (N - 1)'((chain << frac_len) | (2 * N)'(frac))
                                : (N - 1)'(chain >> -frac_len);

  // nearest, ties to even; a clamped regime saturates instead
  assign round_up = ~k_is_oob & round_bit & (sticky_bit | body[0]);

  assign mag         = {1'b0, body} + posit_t'(round_up);
  assign signed_word = sign ? -mag : mag;

  assign word = is_nar ? POSIT_NAR : (is_zero ? '0 : signed_word);

  always_comb begin
    if (!$isunknown({is_zero, is_nar, word}) && !is_zero && !is_nar) begin
      assert #0 (word != '0 && word != POSIT_NAR)
        else $error("posit_encode: finite nonzero product encoded as %h", word);
    end
  end

endmodule : posit_encode

/* rtl/posit_mul.sv */
`timescale 1ns/1ps

module posit_mul (
  input  logic                              sign_a,
  input  logic signed [ppu_pkg::K_SIZE-1:0] k_a,
  input  logic [ppu_pkg::ES-1:0]            exp_a,
  input  logic [ppu_pkg::MANT_SIZE:0]       mant_a,
  input  logic                              is_zero_a,
  input  logic                              is_nar_a,
  input  logic                              sign_b,
  input  logic signed [ppu_pkg::K_SIZE-1:0] k_b,
  input  logic [ppu_pkg::ES-1:0]            exp_b,
  input  logic [ppu_pkg::MANT_SIZE:0]       mant_b,
  input  logic                              is_zero_b,
  input  logic                              is_nar_b,
  output ppu_pkg::product_t                 prod
);
  import ppu_pkg::*;

  logic signed [TE_SIZE-1:0] te_a;
  logic signed [TE_SIZE-1:0] te_b;
  logic [FRAC_FULL_SIZE-1:0] mant_prod;
  logic [FRAC_FULL_SIZE-1:0] mant_norm;
  logic                      ovf;

  // k * 2^ES + exp is just k and exp side by side
  assign te_a = {{(TE_SIZE - K_SIZE - ES){k_a[K_SIZE-1]}}, k_a, exp_a};
  assign te_b = {{(TE_SIZE - K_SIZE - ES){k_b[K_SIZE-1]}}, k_b, exp_b};

  assign mant_prod = mant_a * mant_b;
  assign ovf       = mant_prod[FRAC_FULL_SIZE-1];  // product in [2, 4)
  assign mant_norm = ovf ? mant_prod >> 1 : mant_prod;

  always_comb begin
    prod.sign           = sign_a ^ sign_b;
    prod.is_nar         = is_nar_a | is_nar_b;
    prod.is_zero        = ~(is_nar_a | is_nar_b) & (is_zero_a | is_zero_b);
    prod.frac_full      = {mant_norm[FRAC_FULL_SIZE-3:0], 2'b00};
    prod.total_exp      = te_a + te_b + ovf;
    prod.frac_truncated = ovf & mant_prod[0];
  end

endmodule : posit_mul

/* rtl/ppu_pkg.sv */
package ppu_pkg;

  localparam int N  = 8;
  localparam int ES = 1;

  // regime value of an exact product, before clamping to the word
  localparam int K_SIZE         = $clog2(N) + 2;
  localparam int TE_SIZE        = K_SIZE + ES + 1;  // k * 2^ES + exp of a product, signed
  localparam int MANT_SIZE      = N - 3 - ES;       // fraction bits, hidden bit excluded
  localparam int FRAC_FULL_SIZE = 2 * (MANT_SIZE + 1);
  localparam int REG_LEN_SIZE   = $clog2(N) + 1;
  localparam int MANT_LEN_SIZE  = $clog2(N) + 1;    // signed, goes negative past the word end
  localparam int S              = $clog2(FRAC_FULL_SIZE);

  typedef logic [N-1:0] posit_t;

  localparam posit_t POSIT_NAR = {1'b1, {(N - 1){1'b0}}};

  // product of two decoded operands, carried by the first pipeline stage
  typedef struct packed {
    logic                      sign;
    logic                      is_zero;
    logic                      is_nar;
    logic [FRAC_FULL_SIZE-1:0] frac_full;       // left aligned, hidden bit removed
    logic signed [TE_SIZE-1:0] total_exp;
    logic                      frac_truncated;  // a 1 was shifted out during normalization
  } product_t;

  function automatic int min(input int a, input int b);
    if (a < b) begin
      return a;
    end
    return b;
  endfunction

  function automatic int max(input int a, input int b);
    if (a > b) begin
      return a;
    end
    return b;
  endfunction

endpackage : ppu_pkg

/* rtl/ppu_stage.sv */
`timescale 1ns/1ps

module ppu_stage #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     up_valid,
  output logic     up_ready,
  input  payload_t up_data,
  output logic     down_valid,
  input  logic     down_ready,
  output payload_t down_data
);

  logic load;

  assign up_ready = ~down_valid | down_ready;  // empty slot or draining this cycle
  assign load     = up_valid & up_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      down_valid <= 1'b0;
    end else if (load) begin
      down_valid <= 1'b1;
    end else if (down_ready) begin
      down_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      down_data <= up_data;
    end
  end

  a_hold_stable : assert property (@(posedge clk) disable iff (rst)
    down_valid && !down_ready |=> down_valid && $stable(down_data))
    else $error("ppu_stage: output changed while stalled");

endmodule : ppu_stage

/* rtl/ppu_top.sv */
`timescale 1ns/1ps

module ppu_top (
  input  logic            clk,
  input  logic            rst,
  input  logic            in_valid,
  output logic            in_ready,
  input  ppu_pkg::posit_t operand_a,
  input  ppu_pkg::posit_t operand_b,
  output logic            out_valid,
  input  logic            out_ready,
  output ppu_pkg::posit_t result
);
  import ppu_pkg::*;

  logic                      sign_a;
  logic signed [K_SIZE-1:0]  k_a;
  logic [ES-1:0]             exp_a;
  logic [MANT_SIZE:0]        mant_a;
  logic                      is_zero_a;
  logic                      is_nar_a;
  logic                      sign_b;
  logic signed [K_SIZE-1:0]  k_b;
  logic [ES-1:0]             exp_b;
  logic [MANT_SIZE:0]        mant_b;
  logic                      is_zero_b;
  logic                      is_nar_b;
  product_t                  prod;
  product_t                  s1_prod;
  logic                      s1_valid;
  logic                      s1_ready;
  logic signed [K_SIZE-1:0]  k;
  logic [ES-1:0]             next_exp;
  logic [MANT_SIZE-1:0]      frac;
  logic                      round_bit;
  logic                      sticky_bit;
  logic                      k_is_oob;
  posit_t                    enc_word;

  posit_decode decode_a_inst (
    .word(operand_a), .sign(sign_a), .k(k_a), .exp(exp_a), .mant(mant_a),
    .is_zero(is_zero_a), .is_nar(is_nar_a)
  );

  posit_decode decode_b_inst (
    .word(operand_b), .sign(sign_b), .k(k_b), .exp(exp_b), .mant(mant_b),
    .is_zero(is_zero_b), .is_nar(is_nar_b)
  );

  posit_mul posit_mul_inst (
    .sign_a(sign_a), .k_a(k_a), .exp_a(exp_a), .mant_a(mant_a),
    .is_zero_a(is_zero_a), .is_nar_a(is_nar_a),
    .sign_b(sign_b), .k_b(k_b), .exp_b(exp_b), .mant_b(mant_b),
    .is_zero_b(is_zero_b), .is_nar_b(is_nar_b),
    .prod(prod)
  );

  ppu_stage #(.payload_t(product_t)) stage1_inst (
    .clk(clk), .rst(rst),
    .up_valid(in_valid), .up_ready(in_ready), .up_data(prod),
    .down_valid(s1_valid), .down_ready(s1_ready), .down_data(s1_prod)
  );

  pack_fields pack_fields_inst (
    .frac_full(s1_prod.frac_full), .total_exp(s1_prod.total_exp),
    .frac_truncated(s1_prod.frac_truncated),
    .k(k), .next_exp(next_exp), .frac(frac),
    .round_bit(round_bit), .sticky_bit(sticky_bit), .k_is_oob(k_is_oob),
    .non_zero_frac_field_size()
  );

  posit_encode posit_encode_inst (
    .sign(s1_prod.sign), .is_zero(s1_prod.is_zero), .is_nar(s1_prod.is_nar),
    .k(k), .next_exp(next_exp), .frac(frac),
    .round_bit(round_bit), .sticky_bit(sticky_bit), .k_is_oob(k_is_oob),
    .word(enc_word)
  );

  ppu_stage #(.payload_t(posit_t)) stage2_inst (
    .clk(clk), .rst(rst),
    .up_valid(s1_valid), .up_ready(s1_ready), .up_data(enc_word),
    .down_valid(out_valid), .down_ready(out_ready), .down_data(result)
  );

endmodule : ppu_top

/* tb.f */
rtl/ppu_pkg.sv
rtl/posit_decode.sv
rtl/posit_mul.sv
rtl/compute_rounding.sv
rtl/pack_fields.sv
rtl/posit_encode.sv
rtl/ppu_stage.sv
rtl/ppu_top.sv
verification/tb_ppu.sv

/* verification/ppu_stimulus.txt */
# columns: operand_a operand_b expected, posit8 with es=1, all hex
# the first vector also serves the latency check
# ordinary products
40 40 40
50 50 60
48 48 52
30 50 40
60 20 40
c0 40 c0
c0 c0 40
b0 48 a8
58 58 69
a8 58 97
7f ff c0
# zero and nar
00 40 00
00 c0 00
7f 00 00
80 40 80
00 80 80
80 80 80
# saturation at maxpos and minpos
7f 7f 7f
7f 60 7f
81 7f 81
81 81 7f
01 01 01
ff 01 ff
7f 50 7f
# rounding, ties to even and sticky
41 41 42
48 41 4a
4c 3c 48
43 43 47
58 41 5a
b8 41 b6
7e 50 7e
7e 58 7f

/* verification/tb_ppu.sv */
`timescale 1ns/1ps

module tb_ppu;
  import ppu_pkg::*;

  localparam int WAIT_LIMIT = 500;  // cycles per wait loop

  logic   clk;
  logic   rst;
  logic   in_valid;
  logic   in_ready;
  posit_t operand_a;
  posit_t operand_b;
  logic   out_valid;
  logic   out_ready;
  posit_t result;

  posit_t vec_a[$];
  posit_t vec_b[$];
  posit_t vec_exp[$];
  posit_t exp_q[$];  // scoreboard, one entry per accepted input
  posit_t a_q[$];
  posit_t b_q[$];
  posit_t drv_a;
  posit_t drv_b;
  posit_t drv_exp;

  int     errors;
  int     timeouts;
  int     n_in;
  int     n_out;
  int     cycle;
  int     in_cycle;
  int     out_cycle;
  logic   random_ready;
  integer seed = 32'h60e7_4e0f;

  ppu_top i_dut (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .operand_a(operand_a),
    .operand_b(operand_b),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .result   (result)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check_result(input posit_t actual, input posit_t expected,
                              input posit_t a, input posit_t b);
    if (actual !== expected) begin
      $display("ERR @%0t: %h * %h expected %h, got %h", $time, a, b, expected, actual);
      errors++;
    end
  endtask

  task automatic check_valid(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
      $display("ERR @%0t: %s expected %b, got %b", $time, what, expected, actual);
      errors++;
    end
  endtask

  task automatic check_latency(input int actual, input int expected);
    if (actual != expected) begin
      $display("ERR @%0t: latency expected %0d cycles, got %0d", $time, expected, actual);
      errors++;
    end
  endtask

  task automatic load_vectors(output bit ok);
    int     fd;
    int     n;
    string  line;
    posit_t a;
    posit_t b;
    posit_t e;
    ok = 1'b0;
    fd = $fopen("verification/ppu_stimulus.txt", "r");
    if (fd != 0) begin
      while ($fgets(line, fd) != 0) begin
        n = $sscanf(line, "%h %h %h", a, b, e);
        if (n == 3) begin  // comment and blank lines fall through
          vec_a.push_back(a);
          vec_b.push_back(b);
          vec_exp.push_back(e);
        end
      end
      $fclose(fd);
      ok = vec_a.size() > 0;
    end
  endtask

  // call on a falling edge, returns on the falling edge after the transfer
  task automatic drive_vector(input posit_t a, input posit_t b, input posit_t e);
    int start;
    int waited;
    start     = n_in;
    waited    = 0;
    drv_a     = a;
    drv_b     = b;
    drv_exp   = e;
    operand_a = a;
    operand_b = b;
    in_valid  = 1'b1;
    while (n_in == start && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (n_in == start) begin
      $display("timeout: input %h * %h was never accepted", a, b);
      timeouts++;
    end
  endtask

  task automatic wait_results(input int target);
    int waited;
    waited = 0;
    while (n_out < target && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (n_out < target) begin
      $display("timeout: only %0d of %0d results arrived", n_out, target);
      timeouts++;
    end
  endtask

  // transfers are seen on the rising edge, registers update after this block reads them
  always @(posedge clk) begin
    if (!rst && out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        $display("result %h arrived with no input outstanding", result);
        errors++;
      end else begin
        check_result(result, exp_q.pop_front(), a_q.pop_front(), b_q.pop_front());
      end
      out_cycle = cycle;
      n_out++;
    end
    if (!rst && in_valid && in_ready) begin
      exp_q.push_back(drv_exp);
      a_q.push_back(drv_a);
      b_q.push_back(drv_b);
      in_cycle = cycle;
      n_in++;
    end
    cycle++;
  end

  always @(negedge clk) begin
    if (random_ready) begin
      out_ready = ($random(seed) & 3) != 0;  // ready about three cycles in four
    end
  end

  initial begin
    bit loaded;
    rst          = 1'b1;
    in_valid     = 1'b0;
    operand_a    = '0;
    operand_b    = '0;
    out_ready    = 1'b0;
    random_ready = 1'b0;
    errors       = 0;
    timeouts     = 0;
    n_in         = 0;
    n_out        = 0;
    cycle        = 0;
    load_vectors(loaded);
    repeat (10) begin
      @(negedge clk);
      check_valid(out_valid, 1'b0, "out_valid during reset");
    end
    rst = 1'b0;
    @(negedge clk);
    check_valid(out_valid, 1'b0, "out_valid after reset");
    out_ready = 1'b1;
    if (!loaded) begin
      $display("stimulus file could not be read or holds no vectors");
      errors++;
    end else begin
      // lone product with the sink always ready
      drive_vector(vec_a[0], vec_b[0], vec_exp[0]);
      in_valid = 1'b0;
      wait_results(1);
      check_latency(out_cycle - in_cycle, 2);
      random_ready = 1'b1;
      for (int i = 1; i < vec_a.size(); i++) begin
        drive_vector(vec_a[i], vec_b[i], vec_exp[i]);
      end
      in_valid = 1'b0;
      wait_results(vec_a.size());
      random_ready = 1'b0;
      out_ready    = 1'b1;
    end
    if (exp_q.size() != 0) begin
      $display("%0d expected results never came out of the DUT", exp_q.size());
      errors++;
    end
    $display("errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule : tb_ppu
